//--- verilog.f
common/avmm_pkg.sv
logic/avmm_stage.sv
logic/avmm_req_gate.sv
avmm_sram/avmm_req_fifo.sv
avmm_sram/avmm_sram.sv
logic/avmm_reg_bridge_top.sv
verif/tb_avmm_reg_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tb_avmm_reg_bridge -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"

//--- verif/tb_avmm_reg_bridge.sv
// --------------------------------------------------
// Self-checking testbench for the Avalon-MM register bridge.
// Drives one master and checks read data against a reference memory
// --------------------------------------------------

`timescale 1ns/1ps

module tb_avmm_reg_bridge;

    localparam int n_reg_stages = 2;
    // One entry above the reserve, so a single master already reaches almost-full
    localparam int fifo_depth   = 6;
    localparam int n_fill       = 256;
    localparam int n_readback   = 32;
    localparam int n_bytes_test = 32;
    localparam int n_order      = 64;
    localparam int n_load       = 400;
    localparam int n_requests   = n_fill + n_readback + 2 * n_bytes_test + n_order + n_load;
    localparam int limit_ns     = n_requests * (fifo_depth + 4 * n_reg_stages) * 4 + 100;

    logic        mem_slave = 1'b0;
    logic        rst_n;
    logic [7:0]  address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        readdatavalid;

    logic [31:0] ref_mem [256];
    logic [31:0] exp_q [$];
    logic [31:0] exp_head = '0;
    int          exp_count = 0;
    logic [31:0] rng = 32'h2aba4515;
    logic        rst_q = 1'b0;
    logic        rst_qq = 1'b0;
    logic        saw_wait = 1'b0;
    int          errors = 0;
    int          n_rd = 0;
    int          n_rsp = 0;

    avmm_reg_bridge_top
    #(
        .n_reg_stages (n_reg_stages),
        .fifo_depth   (fifo_depth)
    )
    dut
    (
        .mem_slave     (mem_slave),
        .rst_n         (rst_n),
        .address       (address),
        .read          (read),
        .write         (write),
        .writedata     (writedata),
        .byteenable    (byteenable),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

    initial
    begin
        forever #2 mem_slave = ~mem_slave;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Outputs only move on rising edges, so the falling edge sees settled values
    // A request seen here is the one the DUT takes on the next rising edge
    always @(negedge mem_slave)
    begin
        rst_q  <= rst_n;
        rst_qq <= rst_q;
        if (rst_n)
        begin
            if (readdatavalid)
            begin
                n_rsp++;
                if (exp_q.size() > 0)
                begin
                    void'(exp_q.pop_front());
                end
            end
            if (write && !waitrequest)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (byteenable[b])
                    begin
                        ref_mem[address][8*b +: 8] = writedata[8*b +: 8];
                    end
                end
            end
            if (read && !waitrequest)
            begin
                exp_q.push_back(ref_mem[address]);
                n_rd++;
            end
            if ((read || write) && waitrequest)
            begin
                saw_wait = 1'b1;
            end
            exp_count = exp_q.size();
            exp_head  = (exp_q.size() > 0) ? exp_q[0] : '0;
        end
    end

    // Both outputs stay low through reset and after the first edge that sees it released
    assert property (@(negedge mem_slave) (!rst_n || !rst_q || !rst_qq) |-> !waitrequest)
    else
    begin
        $display("Mismatch waitrequest: got %h expected 0", $sampled(waitrequest));
        errors++;
    end

    assert property (@(negedge mem_slave) (!rst_n || !rst_q || !rst_qq) |-> !readdatavalid)
    else
    begin
        $display("Mismatch readdatavalid: got %h expected 0", $sampled(readdatavalid));
        errors++;
    end

    assert property (@(negedge mem_slave) disable iff (!rst_n) readdatavalid |-> exp_count > 0)
    else
    begin
        $display("Unexpected response: readdatavalid rose with no read outstanding");
        errors++;
    end

    // Responses must come back in issue order, so the head of the queue is the reference
    assert property (@(negedge mem_slave) disable iff (!rst_n)
                     readdatavalid |-> readdata == exp_head)
    else
    begin
        $display("Mismatch readdata: got %h expected %h", $sampled(readdata), $sampled(exp_head));
        errors++;
    end

    // Holds the request until the master sees waitrequest low on a rising edge
    task automatic issue(input logic rd, input logic [7:0] a, input logic [31:0] d,
                         input logic [3:0] be);
        logic taken;
        read       = rd;
        write      = !rd;
        address    = a;
        writedata  = d;
        byteenable = be;
        taken      = 1'b0;
        while (!taken)
        begin
            taken = !waitrequest;
            @(posedge mem_slave);
            #1;
        end
    endtask

    // Drops the request lines and waits for every outstanding read to return
    task automatic drain();
        read  = 1'b0;
        write = 1'b0;
        while (exp_count != 0)
        begin
            @(negedge mem_slave);
        end
        @(posedge mem_slave);
        #1;
    endtask

    task automatic report(input string name);
        $display("%s done, errors so far %0d", name, errors);
    endtask

    initial
    begin
        #limit_ns;
        $display("Timeout: the run did not finish in %0d ns", limit_ns);
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        logic [7:0]  a;
        rst_n      = 1'b0;
        read       = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        byteenable = '0;
        repeat (2) @(posedge mem_slave);
        #1;
        rst_n = 1'b1;
        @(posedge mem_slave);
        #1;
        report("test 1 reset state");

        // Odd stride visits every word once, so later reads never hit unwritten memory
        for (int i = 0; i < n_fill; i++)
        begin
            issue(1'b0, 8'((i * 37 + 11) & 255), next_rand(), 4'hf);
        end
        for (int i = 0; i < n_readback; i++)
        begin
            r = next_rand();
            issue(1'b1, r[7:0], '0, 4'hf);
        end
        drain();
        report("test 2 write then read back");

        for (int i = 0; i < n_bytes_test; i++)
        begin
            r = next_rand();
            a = r[15:8];
            issue(1'b0, a, next_rand(), r[3:0]);
            issue(1'b1, a, '0, 4'hf);
        end
        drain();
        report("test 3 byte enables");

        for (int i = 0; i < n_order; i++)
        begin
            r = next_rand();
            issue(1'b1, r[7:0], '0, 4'hf);
        end
        drain();
        report("test 4 ordering under load");

        saw_wait = 1'b0;
        for (int i = 0; i < n_load; i++)
        begin
            r = next_rand();
            issue(r[0], r[15:8], next_rand(), r[7:4]);
        end
        drain();
        assert (saw_wait)
        else
        begin
            $display("waitrequest never rose during the continuous request run");
            errors++;
        end
        assert (n_rsp == n_rd)
        else
        begin
            $display("Mismatch response count: got %h expected %h", n_rsp, n_rd);
            errors++;
        end
        report("test 5 no loss under back-pressure");

        $display("Summary: 5 tests, %0d reads, %0d responses, %0d errors", n_rd, n_rsp, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- logic/avmm_reg_bridge_top.sv
// --------------------------------------------------
// Top level: master port, pipelined request and
// response paths, and the memory behind them
// --------------------------------------------------

`timescale 1ns/1ps

module avmm_reg_bridge_top
#(
    parameter int n_reg_stages         = 2,
    parameter int n_waitrequest_stages = n_reg_stages,
    parameter int fifo_depth           = 16
)
(
    input  logic                        mem_slave,
    input  logic                        rst_n,
    input  logic [avmm_pkg::addr_w-1:0] address,
    input  logic                        read,
    input  logic                        write,
    input  logic [avmm_pkg::data_w-1:0] writedata,
    input  logic [avmm_pkg::be_w-1:0]   byteenable,
    output logic                        waitrequest,
    output logic [avmm_pkg::data_w-1:0] readdata,
    output logic                        readdatavalid
);

    // Room kept free for requests already in the pipe or not yet stopped
    localparam int skid_slots = n_reg_stages + n_waitrequest_stages + 1;

    // Index 0 is the gate or memory output, the last index is the far end
    logic                req_valid_pipe [n_reg_stages+1];
    avmm_pkg::avmm_req_t req_data_pipe  [n_reg_stages+1];
    logic                rsp_valid_pipe [n_reg_stages+1];
    avmm_pkg::avmm_rsp_t rsp_data_pipe  [n_reg_stages+1];
    logic                almost_full;

    avmm_req_gate
    #(
        .n_waitrequest_stages (n_waitrequest_stages)
    )
    u_req_gate
    (
        .mem_slave   (mem_slave),
        .rst_n       (rst_n),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .almost_full (almost_full),
        .waitrequest (waitrequest),
        .req_valid   (req_valid_pipe[0]),
        .req         (req_data_pipe[0])
    );

    // Request path toward the memory
    for (genvar s = 1; s <= n_reg_stages; s++)
    begin : req_pipe
        avmm_stage #(.payload_t(avmm_pkg::avmm_req_t)) u_stage
        (
            .mem_slave (mem_slave),
            .rst_n     (rst_n),
            .in_valid  (req_valid_pipe[s-1]),
            .in_data   (req_data_pipe[s-1]),
            .out_valid (req_valid_pipe[s]),
            .out_data  (req_data_pipe[s])
        );
    end

    avmm_sram
    #(
        .fifo_depth (fifo_depth),
        .skid_slots (skid_slots)
    )
    u_sram
    (
        .mem_slave   (mem_slave),
        .rst_n       (rst_n),
        .req_valid   (req_valid_pipe[n_reg_stages]),
        .req         (req_data_pipe[n_reg_stages]),
        .almost_full (almost_full),
        .rsp_valid   (rsp_valid_pipe[0]),
        .rsp         (rsp_data_pipe[0])
    );

    // Response path back to the master, same depth as the request path
    for (genvar s = 1; s <= n_reg_stages; s++)
    begin : rsp_pipe
        avmm_stage #(.payload_t(avmm_pkg::avmm_rsp_t)) u_stage
        (
            .mem_slave (mem_slave),
            .rst_n     (rst_n),
            .in_valid  (rsp_valid_pipe[s-1]),
            .in_data   (rsp_data_pipe[s-1]),
            .out_valid (rsp_valid_pipe[s]),
            .out_data  (rsp_data_pipe[s])
        );
    end

    assign readdatavalid = rsp_valid_pipe[n_reg_stages];
    assign readdata      = rsp_data_pipe[n_reg_stages].readdata;

endmodule

//--- avmm_sram/avmm_sram.sv
// --------------------------------------------------
// Word memory with byte enables behind the request
// FIFO; drains one request per cycle, returns reads
// --------------------------------------------------

`timescale 1ns/1ps

module avmm_sram
#(
    parameter int fifo_depth = 16,
    parameter int skid_slots = 5
)
(
    input  logic                mem_slave,
    input  logic                rst_n,
    input  logic                req_valid,
    input  avmm_pkg::avmm_req_t req,
    output logic                almost_full,
    output logic                rsp_valid,
    output avmm_pkg::avmm_rsp_t rsp
);

    localparam int n_words = 2 ** avmm_pkg::addr_w;

    // Memory array; its contents are undefined after reset
    logic [avmm_pkg::data_w-1:0] mem [n_words];

    avmm_pkg::avmm_req_t head;
    logic                fifo_empty;
    logic                pop;

    // Everything arriving from the request stages is queued here
    avmm_req_fifo
    #(
        .fifo_depth (fifo_depth),
        .skid_slots (skid_slots)
    )
    u_req_fifo
    (
        .mem_slave   (mem_slave),
        .rst_n       (rst_n),
        .push        (req_valid),
        .push_data   (req),
        .pop         (pop),
        .pop_data    (head),
        .empty       (fifo_empty),
        .almost_full (almost_full)
    );

    // The memory never stalls, so it takes one entry every cycle it can
    assign pop = !fifo_empty;

    // Byte-wise write of the head entry
    // Disabled lanes keep their old contents
    always_ff @(posedge mem_slave)
    begin
        if (pop && head.write)
        begin
            for (int b = 0; b < avmm_pkg::be_w; b++)
            begin
                if (head.byteenable[b])
                begin
                    mem[head.address][8*b +: 8] <= head.writedata[8*b +: 8];
                end
            end
        end
    end

    // Read data is registered, giving one cycle from pop to response
    always_ff @(posedge mem_slave)
    begin
        if (pop && head.read)
        begin
            rsp.readdata <= mem[head.address];
        end
    end

    // One-cycle valid pulse per read; nothing can stall it
    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= pop && head.read;
        end
    end

endmodule

//--- avmm_sram/avmm_req_fifo.sv
// --------------------------------------------------
// Request queue in front of the memory, with an early
// almost-full flag that covers requests in flight
// --------------------------------------------------

`timescale 1ns/1ps

module avmm_req_fifo
#(
    parameter int fifo_depth = 16,
    parameter int skid_slots = 5
)
(
    input  logic                mem_slave,
    input  logic                rst_n,
    input  logic                push,
    input  avmm_pkg::avmm_req_t push_data,
    input  logic                pop,
    output avmm_pkg::avmm_req_t pop_data,
    output logic                empty,
    output logic                almost_full
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    // Storage, no reset since entries are qualified by the count
    avmm_pkg::avmm_req_t buffer [fifo_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] free_cnt;
    logic             do_push;
    logic             do_pop;

    // Pops from an empty queue are ignored
    assign do_pop  = pop && !empty;
    assign do_push = push;

    // Write the incoming entry at the tail
    always_ff @(posedge mem_slave)
    begin
        if (do_push)
        begin
            buffer[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at fifo_depth so any depth works, not just powers of two
    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    // Head entry is visible as soon as it is written
    assign pop_data = buffer[rd_ptr];
    assign empty    = (count == '0);

    // Flag rises while there is still room for every request in flight
    assign free_cnt    = cnt_w'(fifo_depth) - count;
    assign almost_full = (free_cnt <= cnt_w'(skid_slots));

endmodule

//--- logic/avmm_req_gate.sv
// --------------------------------------------------
// Master-side entry of the bridge: decides acceptance
// and delays almost_full into waitrequest
// --------------------------------------------------

`timescale 1ns/1ps

module avmm_req_gate
#(
    parameter int n_waitrequest_stages = 2
)
(
    input  logic                        mem_slave,
    input  logic                        rst_n,
    input  logic [avmm_pkg::addr_w-1:0] address,
    input  logic                        read,
    input  logic                        write,
    input  logic [avmm_pkg::data_w-1:0] writedata,
    input  logic [avmm_pkg::be_w-1:0]   byteenable,
    input  logic                        almost_full,
    output logic                        waitrequest,
    output logic                        req_valid,
    output avmm_pkg::avmm_req_t         req
);

    // Waitrequest shift register, almost_full enters at the bottom
    logic [n_waitrequest_stages-1:0] wr_shift;

    // Each bit moves up one place per cycle
    // Reset loads zeros so the master sees waitrequest low
    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            wr_shift <= '0;
        end
        else
        begin
            wr_shift[0] <= almost_full;
            for (int i = 1; i < n_waitrequest_stages; i++)
            begin
                wr_shift[i] <= wr_shift[i-1];
            end
        end
    end

    // The oldest sample is what the master sees
    assign waitrequest = wr_shift[n_waitrequest_stages-1];

    // A request is taken only when the master also sees waitrequest low
    // The FIFO reserve covers everything accepted during the delay
    always_comb
    begin
        req.write      = write && !waitrequest;
        req.read       = read && !waitrequest;
        req.address    = address;
        req.writedata  = writedata;
        req.byteenable = byteenable;
        req_valid      = req.write || req.read;
    end

endmodule

//--- logic/avmm_stage.sv
// --------------------------------------------------
// Single register stage, reused for request and
// response payloads through a type parameter
// --------------------------------------------------

`timescale 1ns/1ps

module avmm_stage
#(
    parameter type payload_t = logic
)
(
    input  logic     mem_slave,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Only the valid bit is control state, so only it sees reset
    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
        end
    end

    // Payload follows its input every cycle and is qualified by out_valid
    always_ff @(posedge mem_slave)
    begin
        out_data <= in_data;
    end

endmodule

//--- common/avmm_pkg.sv
// --------------------------------------------------
// Shared widths and request/response structs for the
// Avalon-MM register bridge, referenced by scoped name
// --------------------------------------------------

package avmm_pkg;

    // Word address width, 256 words of storage behind the bridge
    parameter int addr_w = 8;

    // Data bus width in bits
    parameter int data_w = 32;

    // One byte enable per data byte
    parameter int be_w = data_w / 8;

    // One accepted request as it travels down the request stages
    // Read and write are never set together
    typedef struct packed {
        logic              write;
        logic              read;
        logic [addr_w-1:0] address;
        logic [data_w-1:0] writedata;
        logic [be_w-1:0]   byteenable;
    } avmm_req_t;

    // A response only carries data
    // Its arrival is flagged by the valid bit of the stage holding it
    typedef struct packed {
        logic [data_w-1:0] readdata;
    } avmm_rsp_t;

endpackage
